//--- hw/axi_conv_cfg.svh
`ifndef AXI_CONV_CFG_SVH
`define AXI_CONV_CFG_SVH

// Transaction ID width.
`define AXI_ID_W 4

// Byte address width.
`define AXI_ADDR_W 32

// Merge commands that can be outstanding at once.
`define CMD_FIFO_DEPTH 4

`endif

//--- hw/axi_conv_pkg.sv
package axi_conv_pkg;

  // AXI burst type encoding.
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } axi_burst_e;

  // Write response code. Severity rises with the value.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_e;

  // Burst splitter states.
  typedef enum logic {
    SPLIT_IDLE  = 1'b0,
    SPLIT_ISSUE = 1'b1
  } split_state_e;

endpackage

//--- hw/aw_burst_splitter.sv
`timescale 1ns/1ps
`include "axi_conv_cfg.svh"

module aw_burst_splitter
  import axi_conv_pkg::*;
(
  input  logic                   ACLK,
  input  logic                   ARESET,
  input  logic [`AXI_ID_W-1:0]   s_awid,
  input  logic [`AXI_ADDR_W-1:0] s_awaddr,
  input  logic [7:0]             s_awlen,
  input  logic [2:0]             s_awsize,
  input  axi_burst_e             s_awburst,
  input  logic                   s_awvalid,
  output logic                   s_awready,
  output logic [`AXI_ID_W-1:0]   m_awid,
  output logic [`AXI_ADDR_W-1:0] m_awaddr,
  output logic [3:0]             m_awlen,
  output logic [2:0]             m_awsize,
  output axi_burst_e             m_awburst,
  output logic                   m_awvalid,
  input  logic                   m_awready,
  input  logic                   cmd_full,
  output logic                   cmd_push,
  output logic                   cmd_split,
  output logic [3:0]             cmd_repeat
);

  split_state_e           state_q;
  // Pieces still to go after the current one.
  logic [3:0]             pieces_q;
  logic [3:0]             last_len_q;
  logic [`AXI_ID_W-1:0]   id_q;
  logic [`AXI_ADDR_W-1:0] addr_q;
  logic [2:0]             size_q;
  axi_burst_e             burst_q;

  logic                   aw_accept;
  logic                   aw_issue;
  logic [3:0]             in_repeat;
  logic [3:0]             step_shift;
  logic [`AXI_ADDR_W-1:0] addr_step;

  assign s_awready = (state_q == SPLIT_IDLE) && !cmd_full;
  assign aw_accept = s_awvalid && s_awready;
  assign aw_issue  = m_awvalid && m_awready;

  // Upper length bits give the number of extra pieces.
  // WRAP stays whole.
  assign in_repeat = (s_awburst == BURST_WRAP) ? 4'd0 : s_awlen[7:4];

  assign cmd_push   = aw_accept;
  assign cmd_split  = (in_repeat != 4'd0);
  assign cmd_repeat = in_repeat;

  // Sixteen beats of 2^size bytes.
  assign step_shift = {1'b0, size_q} + 4'd4;
  assign addr_step  = {{(`AXI_ADDR_W-1){1'b0}}, 1'b1} << step_shift;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      state_q  <= SPLIT_IDLE;
      pieces_q <= 4'd0;
    end else begin
      case (state_q)
        SPLIT_IDLE: begin
          if (aw_accept) begin
            state_q  <= SPLIT_ISSUE;
            pieces_q <= in_repeat;
          end
        end
        SPLIT_ISSUE: begin
          if (aw_issue) begin
            if (pieces_q == 4'd0) begin
              state_q <= SPLIT_IDLE;
            end else begin
              pieces_q <= pieces_q - 4'd1;
            end
          end
        end
        default: begin
          state_q <= SPLIT_IDLE;
        end
      endcase
    end
  end

  // Burst fields. The address walks forward for INCR only.
  always_ff @(posedge ACLK) begin
    if (aw_accept) begin
      id_q       <= s_awid;
      addr_q     <= s_awaddr;
      size_q     <= s_awsize;
      burst_q    <= s_awburst;
      last_len_q <= s_awlen[3:0];
    end else if (aw_issue && (burst_q == BURST_INCR)) begin
      addr_q <= addr_q + addr_step;
    end
  end

  assign m_awvalid = (state_q == SPLIT_ISSUE);
  assign m_awid    = id_q;
  assign m_awaddr  = addr_q;
  assign m_awsize  = size_q;
  assign m_awburst = burst_q;

  // Full pieces are sixteen beats and the last takes the remainder.
  assign m_awlen = (pieces_q == 4'd0) ? last_len_q : 4'hf;

endmodule

//--- hw/b_cmd_fifo.sv
`timescale 1ns/1ps

module b_cmd_fifo #(
  parameter int DEPTH = 4
) (
  input  logic       ACLK,
  input  logic       ARESET,
  input  logic       cmd_push,
  input  logic       push_split,
  input  logic [3:0] push_repeat,
  output logic       cmd_full,
  output logic       cmd_valid,
  output logic       cmd_split,
  output logic [3:0] cmd_repeat,
  input  logic       cmd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [4:0]       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_next;
  logic             pop;

  assign pop      = cmd_valid && cmd_ready;
  assign cmd_full = (count_q == CNT_W'(DEPTH));

  always_comb begin
    count_next = count_q;
    if (cmd_push && !pop) begin
      count_next = count_q + 1'b1;
    end else if (pop && !cmd_push) begin
      count_next = count_q - 1'b1;
    end
  end

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      cmd_valid <= 1'b0;
    end else begin
      if (cmd_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q   <= count_next;
      cmd_valid <= (count_next != '0);
    end
  end

  always_ff @(posedge ACLK) begin
    if (cmd_push) begin
      mem[wr_ptr_q] <= {push_split, push_repeat};
    end
  end

  assign {cmd_split, cmd_repeat} = mem[rd_ptr_q];

endmodule

//--- hw/b_resp_merger.sv
`timescale 1ns/1ps
`include "axi_conv_cfg.svh"

module b_resp_merger
  import axi_conv_pkg::*;
(
  input  logic                 ACLK,
  input  logic                 ARESET,
  input  logic                 cmd_valid,
  input  logic                 cmd_split,
  input  logic [3:0]           cmd_repeat,
  output logic                 cmd_ready,
  input  logic [`AXI_ID_W-1:0] m_bid,
  input  axi_resp_e            m_bresp,
  input  logic                 m_bvalid,
  output logic                 m_bready,
  output logic [`AXI_ID_W-1:0] s_bid,
  output axi_resp_e            s_bresp,
  output logic                 s_bvalid,
  input  logic                 s_bready
);

  logic       first_q;
  logic [3:0] rep_cnt_q;
  axi_resp_e  resp_acc_q;

  logic       last_resp;
  logic       pop;
  logic [3:0] rep_cnt_pre;
  axi_resp_e  resp_cur;

  // Unsplit commands always sit on their first response.
  assign last_resp = !cmd_split || (!first_q && (rep_cnt_q == 4'd0));

  // Only the final response waits for the upstream side.
  assign m_bready  = cmd_valid && (!last_resp || s_bready);
  assign pop       = m_bvalid && m_bready;
  assign cmd_ready = pop && last_resp;

  assign s_bvalid = m_bvalid && cmd_valid && last_resp;
  assign s_bid    = m_bid;

  // Worst code so far. The first response restarts it.
  always_comb begin
    if (first_q || (m_bresp > resp_acc_q)) begin
      resp_cur = m_bresp;
    end else begin
      resp_cur = resp_acc_q;
    end
  end

  assign s_bresp = resp_cur;

  assign rep_cnt_pre = first_q ? cmd_repeat : rep_cnt_q;

  always_ff @(posedge ACLK) begin
    if (ARESET) begin
      first_q    <= 1'b1;
      rep_cnt_q  <= 4'd0;
      resp_acc_q <= RESP_OKAY;
    end else if (pop) begin
      first_q    <= last_resp;
      rep_cnt_q  <= rep_cnt_pre - 4'd1;
      resp_acc_q <= resp_cur;
    end
  end

endmodule

//--- hw/axi_wr_converter.sv
`timescale 1ns/1ps
`include "axi_conv_cfg.svh"

module axi_wr_converter
  import axi_conv_pkg::*;
(
  input  logic                   ACLK,
  input  logic                   ARESET,
  input  logic [`AXI_ID_W-1:0]   s_awid,
  input  logic [`AXI_ADDR_W-1:0] s_awaddr,
  input  logic [7:0]             s_awlen,
  input  logic [2:0]             s_awsize,
  input  axi_burst_e             s_awburst,
  input  logic                   s_awvalid,
  output logic                   s_awready,
  output logic [`AXI_ID_W-1:0]   m_awid,
  output logic [`AXI_ADDR_W-1:0] m_awaddr,
  output logic [3:0]             m_awlen,
  output logic [2:0]             m_awsize,
  output axi_burst_e             m_awburst,
  output logic                   m_awvalid,
  input  logic                   m_awready,
  input  logic [`AXI_ID_W-1:0]   m_bid,
  input  axi_resp_e              m_bresp,
  input  logic                   m_bvalid,
  output logic                   m_bready,
  output logic [`AXI_ID_W-1:0]   s_bid,
  output axi_resp_e              s_bresp,
  output logic                   s_bvalid,
  input  logic                   s_bready
);

  logic       cmd_push;
  logic       push_split;
  logic [3:0] push_repeat;
  logic       cmd_full;
  logic       cmd_valid;
  logic       cmd_split;
  logic [3:0] cmd_repeat;
  logic       cmd_ready;

  aw_burst_splitter u_splitter (
    .ACLK       (ACLK),
    .ARESET     (ARESET),
    .s_awid     (s_awid),
    .s_awaddr   (s_awaddr),
    .s_awlen    (s_awlen),
    .s_awsize   (s_awsize),
    .s_awburst  (s_awburst),
    .s_awvalid  (s_awvalid),
    .s_awready  (s_awready),
    .m_awid     (m_awid),
    .m_awaddr   (m_awaddr),
    .m_awlen    (m_awlen),
    .m_awsize   (m_awsize),
    .m_awburst  (m_awburst),
    .m_awvalid  (m_awvalid),
    .m_awready  (m_awready),
    .cmd_full   (cmd_full),
    .cmd_push   (cmd_push),
    .cmd_split  (push_split),
    .cmd_repeat (push_repeat)
  );

  b_cmd_fifo #(
    .DEPTH (`CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .ACLK        (ACLK),
    .ARESET      (ARESET),
    .cmd_push    (cmd_push),
    .push_split  (push_split),
    .push_repeat (push_repeat),
    .cmd_full    (cmd_full),
    .cmd_valid   (cmd_valid),
    .cmd_split   (cmd_split),
    .cmd_repeat  (cmd_repeat),
    .cmd_ready   (cmd_ready)
  );

  b_resp_merger u_merger (
    .ACLK       (ACLK),
    .ARESET     (ARESET),
    .cmd_valid  (cmd_valid),
    .cmd_split  (cmd_split),
    .cmd_repeat (cmd_repeat),
    .cmd_ready  (cmd_ready),
    .m_bid      (m_bid),
    .m_bresp    (m_bresp),
    .m_bvalid   (m_bvalid),
    .m_bready   (m_bready),
    .s_bid      (s_bid),
    .s_bresp    (s_bresp),
    .s_bvalid   (s_bvalid),
    .s_bready   (s_bready)
  );

endmodule

//--- tests/tb_axi_wr_converter.sv
`timescale 1ns/1ps
`include "axi_conv_cfg.svh"

module tb_axi_wr_converter
  import axi_conv_pkg::*;
();

  localparam int MAX_CYCLES = 6000;

  logic                   ACLK;
  logic                   ARESET;
  logic [`AXI_ID_W-1:0]   s_awid;
  logic [`AXI_ADDR_W-1:0] s_awaddr;
  logic [7:0]             s_awlen;
  logic [2:0]             s_awsize;
  axi_burst_e             s_awburst;
  logic                   s_awvalid;
  logic                   s_awready;
  logic [`AXI_ID_W-1:0]   m_awid;
  logic [`AXI_ADDR_W-1:0] m_awaddr;
  logic [3:0]             m_awlen;
  logic [2:0]             m_awsize;
  axi_burst_e             m_awburst;
  logic                   m_awvalid;
  logic                   m_awready;
  logic [`AXI_ID_W-1:0]   m_bid;
  axi_resp_e              m_bresp;
  logic                   m_bvalid;
  logic                   m_bready;
  logic [`AXI_ID_W-1:0]   s_bid;
  axi_resp_e              s_bresp;
  logic                   s_bvalid;
  logic                   s_bready;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [15:0] lfsr_q;

  // Slave model records per piece and per burst.
  logic [`AXI_ID_W-1:0] piece_id_q[$];
  logic [`AXI_ID_W-1:0] burst_id_q[$];
  int                   burst_pieces_q[$];
  axi_resp_e            code_q[$];

  axi_wr_converter u_dut (.*);

  initial begin
    ACLK = 1'b0;
    forever #20 ACLK = ~ACLK;
  end

  always @(posedge ACLK) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, the run reached %0d cycles without finishing.", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic random_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  task automatic compare_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("error %s %s: expected 0x%0h, actual 0x%0h", name, field, expected, actual);
    end
  endtask

  // First code sits in the low bits.
  task automatic queue_codes(input logic [7:0] codes, input int count);
    int k;
    for (k = 0; k < count; k++) begin
      code_q.push_back(axi_resp_e'(codes[2*k +: 2]));
    end
  endtask

  task automatic issue_burst(input string name, input logic [`AXI_ID_W-1:0] id,
                             input logic [31:0] addr, input logic [7:0] len,
                             input logic [2:0] size, input axi_burst_e burst,
                             input bit stall);
    int          n;
    int          got;
    logic [31:0] exp_addr;
    logic [3:0]  exp_len;
    // WRAP never splits. Other bursts take sixteen beats per piece.
    n = (burst == BURST_WRAP) ? 1 : int'(len) / 16 + 1;
    s_awid    = id;
    s_awaddr  = addr;
    s_awlen   = len;
    s_awsize  = size;
    s_awburst = burst;
    s_awvalid = 1'b1;
    #1;
    while (!s_awready) begin
      @(negedge ACLK);
      #1;
    end
    @(negedge ACLK);
    s_awvalid = 1'b0;
    got = 0;
    while (got < n) begin
      m_awready = stall ? random_bit() : 1'b1;
      #1;
      if (m_awvalid && m_awready) begin
        exp_addr = (burst == BURST_INCR) ? addr + 32'(got * (16 << size)) : addr;
        exp_len  = (got == n - 1) ? 4'(len % 16) : 4'd15;
        compare_value(name, "m_awid", 32'(id), 32'(m_awid));
        compare_value(name, "m_awaddr", exp_addr, m_awaddr);
        compare_value(name, "m_awlen", 32'(exp_len), 32'(m_awlen));
        compare_value(name, "m_awsize", 32'(size), 32'(m_awsize));
        compare_value(name, "m_awburst", 32'(burst), 32'(m_awburst));
        piece_id_q.push_back(m_awid);
        got++;
      end
      @(negedge ACLK);
    end
    m_awready = 1'b0;
    #1;
    compare_value(name, "m_awvalid after last piece", 32'd0, 32'(m_awvalid));
    burst_pieces_q.push_back(n);
    burst_id_q.push_back(id);
    @(negedge ACLK);
  endtask

  // Answers the oldest burst, holding s_bready low for a while on its last piece.
  task automatic answer_burst(input string name, input int hold);
    int                   n;
    int                   k;
    int                   held;
    logic                 last;
    logic [`AXI_ID_W-1:0] exp_id;
    axi_resp_e            code;
    axi_resp_e            worst;
    n      = burst_pieces_q.pop_front();
    exp_id = burst_id_q.pop_front();
    worst  = RESP_OKAY;
    for (k = 0; k < n; k++) begin
      code = code_q.pop_front();
      last = (k == n - 1);
      if (code > worst) begin
        worst = code;
      end
      m_bid    = piece_id_q.pop_front();
      m_bresp  = code;
      m_bvalid = 1'b1;
      s_bready = !last || (hold == 0);
      held     = 0;
      #1;
      while (1) begin
        compare_value(name, "s_bvalid", 32'(last), 32'(s_bvalid));
        compare_value(name, "m_bready", 32'(!last || s_bready), 32'(m_bready));
        if (last) begin
          compare_value(name, "s_bid", 32'(exp_id), 32'(s_bid));
          compare_value(name, "s_bresp", 32'(worst), 32'(s_bresp));
        end
        if (m_bready) begin
          break;
        end
        @(negedge ACLK);
        held++;
        if (held >= hold) begin
          s_bready = 1'b1;
        end
        #1;
      end
      @(negedge ACLK);
    end
    m_bvalid = 1'b0;
    s_bready = 1'b1;
  endtask

  // A stray downstream response must not leak upstream without a command.
  task automatic verify_reset_state();
    m_bvalid = 1'b1;
    #1;
    compare_value("reset_state", "m_awvalid", 32'd0, 32'(m_awvalid));
    compare_value("reset_state", "s_bvalid", 32'd0, 32'(s_bvalid));
    compare_value("reset_state", "m_bready", 32'd0, 32'(m_bready));
    compare_value("reset_state", "s_awready", 32'd1, 32'(s_awready));
    @(negedge ACLK);
    m_bvalid = 1'b0;
  endtask

  task automatic pass_single_pieces();
    issue_burst("pass_incr", 4'h3, 32'h0000_1000, 8'd7, 3'd2, BURST_INCR, 1'b0);
    code_q.push_back(RESP_SLVERR);
    answer_burst("pass_incr", 0);
    issue_burst("pass_wrap", 4'h5, 32'h0000_2040, 8'd15, 3'd2, BURST_WRAP, 1'b0);
    code_q.push_back(RESP_EXOKAY);
    answer_burst("pass_wrap", 0);
  endtask

  task automatic split_long_incr();
    issue_burst("long_incr", 4'ha, 32'h0001_0000, 8'd255, 3'd2, BURST_INCR, 1'b1);
    repeat (16) code_q.push_back(RESP_OKAY);
    answer_burst("long_incr", 0);
  endtask

  task automatic split_fixed_remainder();
    issue_burst("fixed_split", 4'h6, 32'h0000_3008, 8'd40, 3'd3, BURST_FIXED, 1'b1);
    queue_codes({RESP_OKAY, RESP_OKAY, RESP_EXOKAY, RESP_OKAY}, 3);
    answer_burst("fixed_split", 0);
  endtask

  task automatic merge_case(input string name, input logic [`AXI_ID_W-1:0] id,
                            input logic [7:0] codes);
    issue_burst(name, id, 32'h0000_4000, 8'd63, 3'd2, BURST_INCR, 1'b0);
    queue_codes(codes, 4);
    answer_burst(name, 0);
  endtask

  task automatic merge_responses();
    merge_case("merge_1", 4'h1, {RESP_DECERR, RESP_EXOKAY, RESP_SLVERR, RESP_OKAY});
    merge_case("merge_2", 4'h2, {RESP_OKAY, RESP_EXOKAY, RESP_OKAY, RESP_DECERR});
    merge_case("merge_3", 4'h4, {RESP_OKAY, RESP_SLVERR, RESP_EXOKAY, RESP_OKAY});
    merge_case("merge_4", 4'h7, {RESP_EXOKAY, RESP_OKAY, RESP_OKAY, RESP_OKAY});
    // All OKAY after an EXOKAY result.
    merge_case("merge_reload", 4'h9, 8'h00);
  endtask

  task automatic queue_under_backpressure();
    int i;
    for (i = 0; i < 4; i++) begin
      issue_burst("backpressure", 4'(4'hc + i), 32'h0002_0000 + 32'(i) * 32'h100,
                  (i % 2 == 0) ? 8'd31 : 8'd9, 3'd2, BURST_INCR, 1'b1);
    end
    queue_codes({RESP_OKAY, RESP_EXOKAY, RESP_SLVERR, RESP_OKAY}, 3);
    queue_codes({RESP_OKAY, RESP_OKAY, RESP_OKAY, RESP_DECERR}, 3);
    for (i = 0; i < 4; i++) begin
      answer_burst("backpressure", 3);
    end
  endtask

  initial begin
    lfsr_q    = 16'd96;
    ARESET    = 1'b1;
    s_awid    = '0;
    s_awaddr  = '0;
    s_awlen   = '0;
    s_awsize  = '0;
    s_awburst = BURST_INCR;
    s_awvalid = 1'b0;
    m_awready = 1'b0;
    m_bid     = '0;
    m_bresp   = RESP_OKAY;
    m_bvalid  = 1'b0;
    s_bready  = 1'b1;
    repeat (2) @(posedge ACLK);
    @(negedge ACLK);
    ARESET = 1'b0;
    verify_reset_state();
    pass_single_pieces();
    split_long_incr();
    split_fixed_remainder();
    merge_responses();
    queue_under_backpressure();
    @(negedge ACLK);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+hw
hw/axi_conv_pkg.sv
hw/aw_burst_splitter.sv
hw/b_cmd_fifo.sv
hw/b_resp_merger.sv
hw/axi_wr_converter.sv
tests/tb_axi_wr_converter.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --timing --assert
SIM_FLAGS  := --binary
TOP        := tb_axi_wr_converter
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
